// ==== common/axi_ser_pkg.sv ====
// AXI serializer package with widths, queue depths, channel structs and request/response bundles
package axi_ser_pkg;

  // Bus widths
  localparam int unsigned ID_WIDTH   = 4;
  localparam int unsigned ADDR_WIDTH = 8;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned LEN_WIDTH  = 4;

  // Memory behind the slave covers the whole word address space
  localparam int unsigned MEM_WORDS = 2 ** ADDR_WIDTH;

  // Default number of outstanding transactions in the serializer
  localparam int unsigned MAX_RD_TXNS = 2;
  localparam int unsigned MAX_WR_TXNS = 2;

  // Depth of the AW and AR queues in the memory slave
  localparam int unsigned MEM_QUEUE_DEPTH = 4;

  // Only OKAY responses are produced
  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef logic [ID_WIDTH-1:0]   id_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [LEN_WIDTH-1:0]  len_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } b_chan_t;

  typedef struct packed {
    id_t        id;
    data_t      data;
    logic [1:0] resp;
    logic       last;
  } r_chan_t;

  // Everything the master drives
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything the slave drives
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

endpackage

// ==== verilog/id_fifo.sv ====
// Fall-through FIFO with a payload type parameter and a depth parameter
`timescale 1ns/1ps

module id_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  T              mem_q [DEPTH];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [CntW-1:0] count_q;

  logic empty;
  logic push;
  logic pop;
  logic bypass;

  assign empty = (count_q == '0);

  // Space depends only on the fill level, so a push is refused when full
  assign ready_o = (count_q != CntW'(DEPTH));

  // An empty queue hands the input straight to the output
  always_comb begin
    if (empty) begin
      data_o  = data_i;
      valid_o = valid_i;
    end else begin
      data_o  = mem_q[rd_ptr_q];
      valid_o = 1'b1;
    end
  end

  assign push   = valid_i & ready_o;
  assign pop    = valid_o & ready_i;
  // Entry consumed in the same cycle it arrives never touches storage
  assign bypass = push & pop & empty;

  always_ff @(posedge clk_i) begin
    if (push && !bypass) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push && !bypass) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop && !bypass) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== axi_serializer/axi_serializer.sv ====
// AXI transaction serializer forcing downstream IDs to zero and restoring upstream IDs
`timescale 1ns/1ps

module axi_serializer #(
  parameter int unsigned MaxReadTxns  = axi_ser_pkg::MAX_RD_TXNS,
  parameter int unsigned MaxWriteTxns = axi_ser_pkg::MAX_WR_TXNS
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axi_ser_pkg::axi_req_t  slv_req_i,
  output axi_ser_pkg::axi_resp_t slv_resp_o,
  output axi_ser_pkg::axi_req_t  mst_req_o,
  input  axi_ser_pkg::axi_resp_t mst_resp_i
);

  logic             rd_fifo_ready;
  logic             rd_fifo_valid;
  logic             wr_fifo_ready;
  logic             wr_fifo_valid;
  axi_ser_pkg::id_t b_id;
  axi_ser_pkg::id_t r_id;

  logic aw_fire;
  logic b_fire;
  logic ar_fire;
  logic r_last_fire;

  always_comb begin
    mst_req_o  = slv_req_i;
    slv_resp_o = mst_resp_i;

    // Everything downstream shares ID zero, which keeps the slave strictly in order
    mst_req_o.aw.id = '0;
    mst_req_o.ar.id = '0;

    // Responses carry the ID of the oldest outstanding request
    slv_resp_o.b.id = b_id;
    slv_resp_o.r.id = r_id;

    // Requests only pass when there is room to remember their ID
    mst_req_o.aw_valid  = slv_req_i.aw_valid & wr_fifo_ready;
    slv_resp_o.aw_ready = mst_resp_i.aw_ready & wr_fifo_ready;
    mst_req_o.ar_valid  = slv_req_i.ar_valid & rd_fifo_ready;
    slv_resp_o.ar_ready = mst_resp_i.ar_ready & rd_fifo_ready;

    // Responses only pass when an ID is waiting for them
    slv_resp_o.b_valid = mst_resp_i.b_valid & wr_fifo_valid;
    mst_req_o.b_ready  = slv_req_i.b_ready & wr_fifo_valid;
    slv_resp_o.r_valid = mst_resp_i.r_valid & rd_fifo_valid;
    mst_req_o.r_ready  = slv_req_i.r_ready & rd_fifo_valid;
  end

  assign aw_fire     = slv_req_i.aw_valid & slv_resp_o.aw_ready;
  assign b_fire      = slv_resp_o.b_valid & slv_req_i.b_ready;
  assign ar_fire     = slv_req_i.ar_valid & slv_resp_o.ar_ready;
  // A read ID retires with the final beat of its burst
  assign r_last_fire = slv_resp_o.r_valid & slv_req_i.r_ready & slv_resp_o.r.last;

  id_fifo #(
    .T     (axi_ser_pkg::id_t),
    .DEPTH (MaxWriteTxns)
  ) wr_id_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (slv_req_i.aw.id),
    .valid_i (aw_fire),
    .ready_o (wr_fifo_ready),
    .data_o  (b_id),
    .valid_o (wr_fifo_valid),
    .ready_i (b_fire)
  );

  id_fifo #(
    .T     (axi_ser_pkg::id_t),
    .DEPTH (MaxReadTxns)
  ) rd_id_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (slv_req_i.ar.id),
    .valid_i (ar_fire),
    .ready_o (rd_fifo_ready),
    .data_o  (r_id),
    .valid_o (rd_fifo_valid),
    .ready_i (r_last_fire)
  );

endmodule

// ==== verilog/axi_mem_slave.sv ====
// In-order AXI memory slave with queued AW and AR, burst writes and burst reads
`timescale 1ns/1ps

module axi_mem_slave (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axi_ser_pkg::axi_req_t  req_i,
  output axi_ser_pkg::axi_resp_t resp_o
);

  typedef enum logic {
    WR_DATA,
    WR_RESP
  } wr_state_e;

  axi_ser_pkg::data_t mem_q [axi_ser_pkg::MEM_WORDS];

  axi_ser_pkg::aw_chan_t aw_head;
  logic                  aw_head_valid;
  logic                  aw_queue_ready;
  logic                  aw_pop;
  axi_ser_pkg::ar_chan_t ar_head;
  logic                  ar_head_valid;
  logic                  ar_queue_ready;
  logic                  ar_pop;

  wr_state_e             wr_state_q;
  axi_ser_pkg::len_t     wr_beat_q;
  axi_ser_pkg::addr_t    wr_addr;
  logic                  w_fire;
  logic                  w_last;
  logic                  b_fire;

  logic                  rd_active_q;
  axi_ser_pkg::len_t     rd_beat_q;
  axi_ser_pkg::addr_t    rd_addr;
  logic                  r_fire;
  logic                  r_last;

  id_fifo #(
    .T     (axi_ser_pkg::aw_chan_t),
    .DEPTH (axi_ser_pkg::MEM_QUEUE_DEPTH)
  ) aw_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (req_i.aw),
    .valid_i (req_i.aw_valid),
    .ready_o (aw_queue_ready),
    .data_o  (aw_head),
    .valid_o (aw_head_valid),
    .ready_i (aw_pop)
  );

  id_fifo #(
    .T     (axi_ser_pkg::ar_chan_t),
    .DEPTH (axi_ser_pkg::MEM_QUEUE_DEPTH)
  ) ar_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (req_i.ar),
    .valid_i (req_i.ar_valid),
    .ready_o (ar_queue_ready),
    .data_o  (ar_head),
    .valid_o (ar_head_valid),
    .ready_i (ar_pop)
  );

  // Write path: beats go to consecutive words starting at the head address
  assign wr_addr = aw_head.addr + axi_ser_pkg::addr_t'(wr_beat_q);
  assign w_fire  = req_i.w_valid & resp_o.w_ready;
  assign w_last  = (wr_beat_q == aw_head.len);
  assign b_fire  = resp_o.b_valid & req_i.b_ready;
  // The AW stays at the head until its response is taken, so B reuses its ID
  assign aw_pop  = b_fire;

  // Read path: the beat counter walks the burst of the head AR
  assign rd_addr = ar_head.addr + axi_ser_pkg::addr_t'(rd_beat_q);
  assign r_last  = (rd_beat_q == ar_head.len);
  assign r_fire  = resp_o.r_valid & req_i.r_ready;
  assign ar_pop  = r_fire & r_last;

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = aw_queue_ready;
    resp_o.ar_ready = ar_queue_ready;
    resp_o.w_ready  = (wr_state_q == WR_DATA) & aw_head_valid;
    resp_o.b_valid  = (wr_state_q == WR_RESP);
    resp_o.b.id     = aw_head.id;
    resp_o.b.resp   = axi_ser_pkg::RESP_OKAY;
    resp_o.r_valid  = rd_active_q;
    resp_o.r.id     = ar_head.id;
    resp_o.r.data   = mem_q[rd_addr];
    resp_o.r.resp   = axi_ser_pkg::RESP_OKAY;
    resp_o.r.last   = r_last;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < axi_ser_pkg::MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (w_fire) begin
      mem_q[wr_addr] <= req_i.w.data;
    end
  end

  // Write FSM collects the data beats, then holds B until it is accepted
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_state_q <= WR_DATA;
      wr_beat_q  <= '0;
    end else begin
      case (wr_state_q)
        WR_DATA: begin
          if (w_fire) begin
            if (w_last) begin
              wr_state_q <= WR_RESP;
              wr_beat_q  <= '0;
            end else begin
              wr_beat_q <= wr_beat_q + 1'b1;
            end
          end
        end
        WR_RESP: begin
          if (b_fire) begin
            wr_state_q <= WR_DATA;
          end
        end
        default: wr_state_q <= WR_DATA;
      endcase
    end
  end

  // A burst starts one cycle after its AR reaches the head of the queue
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_active_q <= 1'b0;
      rd_beat_q   <= '0;
    end else if (!rd_active_q) begin
      rd_active_q <= ar_head_valid;
    end else if (r_fire) begin
      if (r_last) begin
        rd_active_q <= 1'b0;
        rd_beat_q   <= '0;
      end else begin
        rd_beat_q <= rd_beat_q + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/axi_ser_top.sv ====
// Top level joining the AXI serializer to the in-order memory slave
`timescale 1ns/1ps

module axi_ser_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axi_ser_pkg::axi_req_t  slv_req_i,
  output axi_ser_pkg::axi_resp_t slv_resp_o
);

  // Link between the serializer and the memory
  axi_ser_pkg::axi_req_t  mst_req;
  axi_ser_pkg::axi_resp_t mst_resp;

  axi_serializer #(
    .MaxReadTxns  (axi_ser_pkg::MAX_RD_TXNS),
    .MaxWriteTxns (axi_ser_pkg::MAX_WR_TXNS)
  ) axi_serializer_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .slv_req_i  (slv_req_i),
    .slv_resp_o (slv_resp_o),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp)
  );

  axi_mem_slave axi_mem_slave_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (mst_req),
    .resp_o  (mst_resp)
  );

endmodule

// ==== test/tb_clk_gen.sv ====
// Testbench clock and reset generator
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset spans two rising edges and is released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== test/axi_ser_properties.sv ====
// Concurrent assertions on the serializer ID handling and upstream handshakes, with their bind
`timescale 1ns/1ps

module axi_ser_properties (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input axi_ser_pkg::axi_req_t  slv_req_i,
  input axi_ser_pkg::axi_resp_t slv_resp_i,
  input axi_ser_pkg::axi_req_t  mst_req_i,
  input logic                   wr_fifo_valid_i
);

  // Downstream traffic always uses ID zero
  aw_id_zero_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_req_i.aw_valid |-> (mst_req_i.aw.id == '0))
    else $error("Downstream AW carries a nonzero ID");

  ar_id_zero_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_req_i.ar_valid |-> (mst_req_i.ar.id == '0))
    else $error("Downstream AR carries a nonzero ID");

  // A stalled upstream AW keeps its payload until it is taken
  aw_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_req_i.aw_valid && !slv_resp_i.aw_ready) |=> $stable(slv_req_i.aw))
    else $error("Upstream AW payload changed while waiting for aw_ready");

  // B only appears upstream while an ID waits in the write queue
  b_needs_id_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(slv_resp_i.b_valid) |-> wr_fifo_valid_i)
    else $error("Upstream b_valid rose with an empty write ID queue");

endmodule

bind axi_serializer axi_ser_properties axi_ser_properties_i (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .slv_req_i       (slv_req_i),
  .slv_resp_i      (slv_resp_o),
  .mst_req_i       (mst_req_o),
  .wr_fifo_valid_i (wr_fifo_valid)
);

// ==== test/axi_ser_tb.sv ====
// Testbench with AXI master stimulus, reference memory, ID order model, checks and report
`timescale 1ns/1ps

module axi_ser_tb;

  // Roughly four times the length of all tests together
  localparam int unsigned CYCLE_LIMIT = 4000;
  localparam int          HOLD_CYCLES = 20;
  localparam int          BURSTS      = 30;

  typedef struct packed {
    axi_ser_pkg::addr_t addr;
    axi_ser_pkg::len_t  len;
  } burst_t;

  logic                   clk;
  logic                   rst_n;
  axi_ser_pkg::axi_req_t  req;
  axi_ser_pkg::axi_resp_t resp;

  axi_ser_pkg::data_t ref_mem [axi_ser_pkg::MEM_WORDS];
  axi_ser_pkg::id_t   b_ids [$];
  axi_ser_pkg::id_t   r_ids [$];
  burst_t             wr_bursts [$];
  burst_t             rd_bursts [$];
  axi_ser_pkg::len_t  w_beat;
  axi_ser_pkg::len_t  r_beat;
  integer             seed;
  int unsigned        cycles;
  int unsigned        checks;
  int unsigned        errors;
  int unsigned        tests_done;

  tb_clk_gen tb_clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  axi_ser_top axi_ser_top_i (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .slv_req_i  (req),
    .slv_resp_o (resp)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  // Expected read data is whatever the last accepted W beat left in that word
  function automatic axi_ser_pkg::data_t ref_read(input axi_ser_pkg::addr_t addr);
    return ref_mem[addr];
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // Puts an address on AW or AR and waits a bounded time for it to be taken
  task automatic offer_addr(input logic is_read, input axi_ser_pkg::id_t id,
                            input axi_ser_pkg::addr_t addr, input axi_ser_pkg::len_t len,
                            output logic taken);
    if (is_read) begin
      req.ar       = '{id: id, addr: addr, len: len};
      req.ar_valid = 1'b1;
    end else begin
      req.aw       = '{id: id, addr: addr, len: len};
      req.aw_valid = 1'b1;
    end
    taken = 1'b0;
    for (int n = 0; n < HOLD_CYCLES && !taken; n++) begin
      @(posedge clk);
      taken = is_read ? resp.ar_ready : resp.aw_ready;
    end
    @(negedge clk);
    if (taken) begin
      req.ar_valid = req.ar_valid & !is_read;
      req.aw_valid = req.aw_valid & is_read;
    end
  endtask

  // Keeps a pending address on the bus until the DUT takes it
  task automatic finish_addr(input logic is_read);
    @(posedge clk);
    while (!(is_read ? resp.ar_ready : resp.aw_ready)) begin
      @(posedge clk);
    end
    @(negedge clk);
    if (is_read) begin
      req.ar_valid = 1'b0;
    end else begin
      req.aw_valid = 1'b0;
    end
  endtask

  task automatic send_addr(input logic is_read, input axi_ser_pkg::id_t id,
                           input axi_ser_pkg::addr_t addr, input axi_ser_pkg::len_t len);
    logic taken;
    offer_addr(is_read, id, addr, len, taken);
    if (!taken) begin
      finish_addr(is_read);
    end
  endtask

  task automatic send_w_burst(input axi_ser_pkg::len_t len);
    for (int beat = 0; beat <= int'(len); beat++) begin
      req.w.data  = rand_word();
      req.w.last  = (beat == int'(len));
      req.w_valid = 1'b1;
      @(posedge clk);
      while (!resp.w_ready) begin
        @(posedge clk);
      end
      @(negedge clk);
    end
    req.w_valid = 1'b0;
  endtask

  task automatic write_burst(input axi_ser_pkg::id_t id, input axi_ser_pkg::addr_t addr,
                             input axi_ser_pkg::len_t len);
    send_addr(1'b0, id, addr, len);
    send_w_burst(len);
  endtask

  // Returns once every issued write has its B and every read its last beat
  task automatic wait_idle();
    while (b_ids.size() != 0 || r_ids.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input string name);
    tests_done++;
    $display("Test %0d (%s) finished, %0d errors so far", tests_done, name, errors);
  endtask

  // Follows every upstream handshake and compares B and R against the models
  always @(posedge clk) begin
    burst_t             wb;
    burst_t             rb;
    axi_ser_pkg::addr_t addr;
    axi_ser_pkg::id_t   exp_id;
    if (rst_n) begin
      if (req.aw_valid && resp.aw_ready) begin
        b_ids.push_back(req.aw.id);
        wr_bursts.push_back({req.aw.addr, req.aw.len});
      end
      if (req.ar_valid && resp.ar_ready) begin
        r_ids.push_back(req.ar.id);
        rd_bursts.push_back({req.ar.addr, req.ar.len});
      end
      if (req.w_valid && resp.w_ready) begin
        if (wr_bursts.size() == 0) begin
          errors++;
          $display("Write data was accepted with no write address outstanding");
        end else begin
          wb            = wr_bursts[0];
          addr          = wb.addr + axi_ser_pkg::addr_t'(w_beat);
          ref_mem[addr] = req.w.data;
          if (w_beat == wb.len) begin
            w_beat = '0;
            wr_bursts.delete(0);
          end else begin
            w_beat++;
          end
        end
      end
      if (resp.b_valid && req.b_ready) begin
        if (b_ids.size() == 0) begin
          errors++;
          $display("A write response arrived with no write outstanding");
        end else begin
          exp_id = b_ids.pop_front();
          check_value("b.id", 32'(exp_id), 32'(resp.b.id));
          check_value("b.resp", 32'(axi_ser_pkg::RESP_OKAY), 32'(resp.b.resp));
        end
      end
      if (resp.r_valid && req.r_ready) begin
        if (rd_bursts.size() == 0) begin
          errors++;
          $display("Read data arrived with no read outstanding");
        end else begin
          rb   = rd_bursts[0];
          addr = rb.addr + axi_ser_pkg::addr_t'(r_beat);
          check_value("r.id", 32'(r_ids[0]), 32'(resp.r.id));
          check_value("r.data", ref_read(addr), resp.r.data);
          check_value("r.resp", 32'(axi_ser_pkg::RESP_OKAY), 32'(resp.r.resp));
          check_value("r.last", 32'(r_beat == rb.len), 32'(resp.r.last));
          if (r_beat == rb.len) begin
            r_beat = '0;
            rd_bursts.delete(0);
            r_ids.delete(0);
          end else begin
            r_beat++;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    axi_ser_pkg::id_t   id;
    axi_ser_pkg::addr_t addr;
    axi_ser_pkg::addr_t t_addr [BURSTS];
    axi_ser_pkg::len_t  t_len [BURSTS];
    logic               taken;
    int unsigned        accepted;
    int unsigned        issued;

    seed        = 32'h888c_6d54;
    cycles      = 0;
    checks      = 0;
    errors      = 0;
    tests_done  = 0;
    w_beat      = '0;
    r_beat      = '0;
    req         = '0;
    req.b_ready = 1'b1;
    req.r_ready = 1'b1;
    for (int i = 0; i < axi_ser_pkg::MEM_WORDS; i++) begin
      ref_mem[axi_ser_pkg::addr_t'(i)] = '0;
    end
    @(posedge rst_n);

    check_value("b_valid", 32'd0, 32'(resp.b_valid));
    check_value("r_valid", 32'd0, 32'(resp.r_valid));
    check_value("aw_ready", 32'd1, 32'(resp.aw_ready));
    check_value("ar_ready", 32'd1, 32'(resp.ar_ready));
    finish_test("reset state");

    addr = axi_ser_pkg::addr_t'(rand_word());
    write_burst(axi_ser_pkg::id_t'(rand_word()), addr, '0);
    wait_idle();
    send_addr(1'b1, axi_ser_pkg::id_t'(rand_word()), addr, '0);
    wait_idle();
    finish_test("single beat write and read");

    for (int i = 0; i < BURSTS; i++) begin
      t_addr[i] = axi_ser_pkg::addr_t'(rand_word());
      t_len[i]  = axi_ser_pkg::len_t'(rand_word());
      write_burst(axi_ser_pkg::id_t'(rand_word()), t_addr[i], t_len[i]);
    end
    wait_idle();
    for (int i = 0; i < BURSTS; i++) begin
      send_addr(1'b1, axi_ser_pkg::id_t'(rand_word()), t_addr[i], t_len[i]);
    end
    wait_idle();
    finish_test("random bursts");

    // Writes stay above 0x80 and reads below, so no read races a write
    id = axi_ser_pkg::id_t'(rand_word());
    for (int i = 0; i < 10; i++) begin
      if (i % 3 != 2) begin
        id = axi_ser_pkg::id_t'(rand_word());
      end
      write_burst(id, 8'h80 | (axi_ser_pkg::addr_t'(rand_word()) & 8'h6f),
                  axi_ser_pkg::len_t'(rand_word()));
      if (i % 3 != 1) begin
        id = axi_ser_pkg::id_t'(rand_word());
      end
      send_addr(1'b1, id, axi_ser_pkg::addr_t'(rand_word()) & 8'h6f,
                axi_ser_pkg::len_t'(rand_word()));
    end
    wait_idle();
    finish_test("interleaved ID order");

    req.b_ready = 1'b0;
    accepted    = 0;
    taken       = 1'b1;
    for (int k = 0; k <= int'(axi_ser_pkg::MAX_WR_TXNS) && taken; k++) begin
      t_addr[k] = axi_ser_pkg::addr_t'(8'h90 + 16 * k);
      t_len[k]  = axi_ser_pkg::len_t'(rand_word());
      offer_addr(1'b0, axi_ser_pkg::id_t'(rand_word()), t_addr[k], t_len[k], taken);
      if (taken) begin
        accepted++;
      end
      // Only the oldest burst can take data while its B is held back
      if (taken && k == 0) begin
        send_w_burst(t_len[0]);
      end
    end
    check_value("aw accepted", 32'(axi_ser_pkg::MAX_WR_TXNS), 32'(accepted));
    issued      = taken ? accepted : accepted + 1;
    req.b_ready = 1'b1;
    if (!taken) begin
      finish_addr(1'b0);
    end
    for (int k = 1; k < int'(issued); k++) begin
      send_w_burst(t_len[k]);
    end
    wait_idle();

    req.r_ready = 1'b0;
    accepted    = 0;
    taken       = 1'b1;
    for (int k = 0; k <= int'(axi_ser_pkg::MAX_RD_TXNS) && taken; k++) begin
      offer_addr(1'b1, axi_ser_pkg::id_t'(rand_word()), t_addr[k], t_len[k], taken);
      if (taken) begin
        accepted++;
      end
    end
    check_value("ar accepted", 32'(axi_ser_pkg::MAX_RD_TXNS), 32'(accepted));
    req.r_ready = 1'b1;
    if (!taken) begin
      finish_addr(1'b1);
    end
    wait_idle();
    finish_test("back-pressure");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
common/axi_ser_pkg.sv
verilog/id_fifo.sv
axi_serializer/axi_serializer.sv
verilog/axi_mem_slave.sv
verilog/axi_ser_top.sv
test/tb_clk_gen.sv
test/axi_ser_properties.sv
test/axi_ser_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
  --top-module axi_ser_tb -Mdir obj_dir -o axi_ser_sim

status=0
output=$(./obj_dir/axi_ser_sim 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1
